// File: source/rv_types_pkg.sv
package rv_types_pkg;

    // instruction address space, byte addressed
    localparam int IADDR_BITS = 16;

    // halfword program counter, byte address bit 0 is always zero
    typedef logic [IADDR_BITS-1:1] pc_t;

    // one 16-bit instruction parcel
    typedef logic [15:0] half_t;

    // full 32-bit instruction or memory word
    typedef logic [31:0] instr_t;

    // word address toward instruction memory
    typedef logic [IADDR_BITS-3:0] word_addr_t;

endpackage

// File: source/rv_fetch_pkg.sv
package rv_fetch_pkg;

    // queue depth in halfwords
    localparam int DEPTH_BITS = 3;
    localparam int QSIZE      = 2 ** DEPTH_BITS;

    // fill count, one extra bit so a full queue fits
    typedef logic [DEPTH_BITS:0] cnt_t;

    // one write into the fetch queue
    typedef struct packed
    {
        rv_types_pkg::half_t lo;     // lower half, used by double pushes
        rv_types_pkg::half_t hi;     // upper half, used by both push kinds
        logic                single; // write hi only
        logic                double; // write lo then hi
    } fetch_push_t;

    // what the queue shows at its head
    typedef struct packed
    {
        rv_types_pkg::half_t lo;     // head parcel
        rv_types_pkg::half_t hi;     // parcel behind it
        rv_types_pkg::pc_t   pc;     // pc of the head parcel
        logic                empty;  // no whole instruction at the head
    } fetch_head_t;

    // one instruction handed to the core
    typedef struct packed
    {
        rv_types_pkg::instr_t instr;
        rv_types_pkg::pc_t    pc;
        logic                 compressed;
    } issue_t;

endpackage

// File: source/rv_fetch_ctrl.sv
`timescale 1ns/100ps

module rv_fetch_ctrl
(
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  rv_types_pkg::pc_t         i_boot_pc,
    input  logic                      i_flush,
    input  rv_types_pkg::pc_t         i_flush_pc,
    input  logic                      i_buf_full,
    input  rv_types_pkg::instr_t      i_mem_rdata,
    output logic                      o_mem_req,
    output rv_types_pkg::word_addr_t  o_mem_addr,
    output rv_fetch_pkg::fetch_push_t o_push
);

    rv_types_pkg::word_addr_t addr;      // word to fetch next
    logic                     pending;   // response due this cycle
    logic                     drop;      // response belongs to the stream before a flush
    logic                     odd_start; // first word starts at its upper half
    logic                     rsp_ok;    // response accepted into the queue

    // no request in reset and at most one in flight since memory answers one cycle later
    assign o_mem_req  = i_reset_n & ~i_buf_full & ~pending & ~i_flush;
    assign o_mem_addr = addr;

    assign rsp_ok = pending & ~drop & ~i_flush;

    always_comb
    begin
        o_push.lo     = i_mem_rdata[15:0];
        o_push.hi     = i_mem_rdata[31:16];
        o_push.single = rsp_ok & odd_start;  // only the upper parcel is wanted
        o_push.double = rsp_ok & ~odd_start;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            addr      <= i_boot_pc[rv_types_pkg::IADDR_BITS-1:2];
            odd_start <= i_boot_pc[1];
            pending   <= 1'b0;
            drop      <= 1'b0;
        end
        else
        begin
            pending <= o_mem_req;
            // a response landing right after a flush is stale
            drop    <= i_flush;
            if (i_flush)
            begin
                addr      <= i_flush_pc[rv_types_pkg::IADDR_BITS-1:2];
                odd_start <= i_flush_pc[1];
            end
            else if (rsp_ok)
            begin
                addr      <= addr + 1'b1;  // sequential fetch
                odd_start <= 1'b0;
            end
        end
    end

endmodule

// File: source/rv_fetch_buf.sv
`timescale 1ns/100ps

module rv_fetch_buf
(
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  rv_types_pkg::pc_t         i_boot_pc,
    input  logic                      i_flush,
    input  rv_types_pkg::pc_t         i_flush_pc,
    input  rv_fetch_pkg::fetch_push_t i_push,
    input  logic                      i_pop,
    output rv_fetch_pkg::fetch_head_t o_head,
    output logic                      o_full
);

    rv_types_pkg::half_t data [rv_fetch_pkg::QSIZE];
    rv_types_pkg::half_t data_next [rv_fetch_pkg::QSIZE];
    rv_types_pkg::half_t ext [rv_fetch_pkg::QSIZE+2];  // queue padded for the shift

    rv_fetch_pkg::cnt_t  count;
    rv_fetch_pkg::cnt_t  pop_cnt;
    rv_fetch_pkg::cnt_t  push_cnt;
    rv_fetch_pkg::cnt_t  cnt_after_pop;  // write position for new halves
    rv_fetch_pkg::cnt_t  cnt_next;

    rv_types_pkg::pc_t   pc;
    rv_types_pkg::pc_t   pc_next;

    logic is_comp;
    logic pop_single;
    logic pop_double;

    // low bits 11 mark a full 32-bit instruction
    assign is_comp    = (data[0][1:0] != 2'b11);
    assign pop_single = i_pop & is_comp;
    assign pop_double = i_pop & ~is_comp;

    assign pop_cnt  = pop_double ? rv_fetch_pkg::cnt_t'(2) :
                      pop_single ? rv_fetch_pkg::cnt_t'(1) : '0;
    assign push_cnt = i_push.double ? rv_fetch_pkg::cnt_t'(2) :
                      i_push.single ? rv_fetch_pkg::cnt_t'(1) : '0;

    assign cnt_after_pop = count - pop_cnt;
    assign cnt_next      = i_flush ? '0 : cnt_after_pop + push_cnt;

    // fewer than two free entries after this edge
    assign o_full = (rv_fetch_pkg::cnt_t'(rv_fetch_pkg::QSIZE) - cnt_next) < 2;

    always_comb
    begin
        for (int i = 0; i < rv_fetch_pkg::QSIZE; i++)
        begin
            ext[i] = data[i];
        end
        ext[rv_fetch_pkg::QSIZE]   = '0;
        ext[rv_fetch_pkg::QSIZE+1] = '0;

        for (int i = 0; i < rv_fetch_pkg::QSIZE; i++)
        begin
            if ((i_push.single && cnt_after_pop == rv_fetch_pkg::cnt_t'(i)) ||
                (i_push.double && rv_fetch_pkg::cnt_t'(cnt_after_pop + 1'b1) ==
                                  rv_fetch_pkg::cnt_t'(i)))
                data_next[i] = i_push.hi;
            else if (i_push.double && cnt_after_pop == rv_fetch_pkg::cnt_t'(i))
                data_next[i] = i_push.lo;
            else if (pop_single)
                data_next[i] = ext[i+1];  // shift down by one parcel
            else if (pop_double)
                data_next[i] = ext[i+2];
            else
                data_next[i] = data[i];
        end
    end

    always_ff @(posedge i_clk)
    begin
        data <= data_next;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            count <= '0;
        else
            count <= cnt_next;
    end

    assign pc_next = pc + (is_comp ? rv_types_pkg::pc_t'(1) : rv_types_pkg::pc_t'(2));

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= i_boot_pc;
        else if (i_flush)
            pc <= i_flush_pc;  // restart at the redirect target
        else if (i_pop)
            pc <= pc_next;
    end

    always_comb
    begin
        o_head.lo    = data[0];
        o_head.hi    = data[1];
        o_head.pc    = pc;
        // a full instruction needs both parcels present
        o_head.empty = (count == '0) || (count == rv_fetch_pkg::cnt_t'(1) && !is_comp);
    end

endmodule

// File: source/rv_instr_issue.sv
`timescale 1ns/100ps

module rv_instr_issue
(
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_flush,
    input  logic                      i_stall,
    input  rv_fetch_pkg::fetch_head_t i_head,
    output logic                      o_pop,
    output logic                      o_issue_valid,
    output rv_fetch_pkg::issue_t      o_issue
);

    rv_fetch_pkg::issue_t issue_d;
    rv_fetch_pkg::issue_t issue_q;
    logic                 valid_q;
    logic                 is_comp;

    assign is_comp = (i_head.lo[1:0] != 2'b11);

    // take a whole instruction whenever the core can accept one
    assign o_pop = ~i_head.empty & ~i_stall;

    always_comb
    begin
        if (is_comp)
            issue_d.instr = {16'h0000, i_head.lo};  // compressed, kept unexpanded
        else
            issue_d.instr = {i_head.hi, i_head.lo};
        issue_d.pc         = i_head.pc;
        issue_d.compressed = is_comp;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            valid_q <= 1'b0;
        else if (i_flush)
            valid_q <= 1'b0;   // old stream must not reach the core
        else if (!i_stall)
            valid_q <= o_pop;
    end

    // payload follows the head, valid tells the core whether to use it
    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
            issue_q <= issue_d;
    end

    assign o_issue_valid = valid_q;
    assign o_issue       = issue_q;

endmodule

// File: source/rv_fetch_top.sv
`timescale 1ns/100ps

module rv_fetch_top
(
    input  logic                     i_clk,
    input  logic                     i_reset_n,
    input  rv_types_pkg::pc_t        i_boot_pc,
    input  logic                     i_flush,
    input  rv_types_pkg::pc_t        i_flush_pc,
    input  rv_types_pkg::instr_t     i_mem_rdata,
    input  logic                     i_stall,
    output logic                     o_mem_req,
    output rv_types_pkg::word_addr_t o_mem_addr,
    output logic                     o_issue_valid,
    output rv_fetch_pkg::issue_t     o_issue
);

    rv_fetch_pkg::fetch_push_t push;
    rv_fetch_pkg::fetch_head_t head;
    logic                      buf_full;
    logic                      pop;

    // memory reads into queue writes
    rv_fetch_ctrl u_fetch_ctrl
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_boot_pc      (i_boot_pc),
        .i_flush        (i_flush),
        .i_flush_pc     (i_flush_pc),
        .i_buf_full     (buf_full),
        .i_mem_rdata    (i_mem_rdata),
        .o_mem_req      (o_mem_req),
        .o_mem_addr     (o_mem_addr),
        .o_push         (push)
    );

    rv_fetch_buf u_fetch_buf
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_boot_pc      (i_boot_pc),
        .i_flush        (i_flush),
        .i_flush_pc     (i_flush_pc),
        .i_push         (push),
        .i_pop          (pop),
        .o_head         (head),
        .o_full         (buf_full)
    );

    // whole instructions toward the core
    rv_instr_issue u_instr_issue
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_flush        (i_flush),
        .i_stall        (i_stall),
        .i_head         (head),
        .o_pop          (pop),
        .o_issue_valid  (o_issue_valid),
        .o_issue        (o_issue)
    );

endmodule

// File: tests/tb_rv_fetch_top.sv
`timescale 1ns/100ps

module tb_rv_fetch_top;

    localparam int N_FIRST       = 10;
    localparam int N_STREAM      = 500;
    localparam int N_ODD         = 200;
    localparam int N_STALL       = 500;
    localparam int N_FLUSHES     = 50;
    localparam int N_MAX_BETWEEN = 16;   // most instructions between two flushes
    localparam int N_TAIL        = 20;
    localparam int INSTR_TOTAL   = N_FIRST + N_STREAM + N_ODD + 1 + N_STALL +
                                   N_FLUSHES * N_MAX_BETWEEN + N_TAIL;
    localparam int MAX_CYCLES    = INSTR_TOTAL * 8 + 200;

    logic                     i_clk;
    logic                     i_reset_n;
    rv_types_pkg::pc_t        i_boot_pc;
    logic                     i_flush;
    rv_types_pkg::pc_t        i_flush_pc;
    rv_types_pkg::instr_t     i_mem_rdata;
    logic                     i_stall;
    logic                     o_mem_req;
    rv_types_pkg::word_addr_t o_mem_addr;
    logic                     o_issue_valid;
    rv_fetch_pkg::issue_t     o_issue;

    rv_types_pkg::half_t      mem [16384];  // instruction memory with one entry per parcel
    logic                     req_seen;
    rv_types_pkg::word_addr_t addr_seen;

    rv_types_pkg::pc_t        exp_pc;       // next pc the model expects
    logic                     mon_en;
    logic                     stall_en;
    logic                     hold_prev;
    logic                     valid_prev;
    rv_fetch_pkg::issue_t     issue_prev;
    int                       n_checked;
    int                       n_total;
    int                       n_errors;
    int                       cycle_cnt;

    rv_fetch_top u_rv_fetch_top
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_boot_pc     (i_boot_pc),
        .i_flush       (i_flush),
        .i_flush_pc    (i_flush_pc),
        .i_mem_rdata   (i_mem_rdata),
        .i_stall       (i_stall),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .o_issue_valid (o_issue_valid),
        .o_issue       (o_issue)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // watchdog bounded by the longest possible run
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES)
        begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // memory answers a request one cycle later
    always @(negedge i_clk)
    begin
        req_seen  = o_mem_req;
        addr_seen = o_mem_addr;
    end

    initial
    begin
        i_mem_rdata = '1;
        forever
        begin
            @(posedge i_clk);
            #1;
            if (req_seen)
                i_mem_rdata = {mem[{addr_seen[12:0], 1'b1}], mem[{addr_seen[12:0], 1'b0}]};
            else
                i_mem_rdata = '1;  // nothing due so the bus carries garbage
        end
    end

    function automatic rv_types_pkg::half_t half_at(input rv_types_pkg::pc_t pc);
        return mem[pc[14:1]];
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            n_errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // next instruction of the reference walk through memory
    task automatic check_issue();
        rv_types_pkg::half_t  lo;
        rv_types_pkg::half_t  hi;
        rv_types_pkg::instr_t exp_instr;
        logic                 comp;
        lo   = half_at(exp_pc);
        hi   = half_at(rv_types_pkg::pc_t'(exp_pc + 1'b1));
        comp = (lo[1:0] != 2'b11);
        exp_instr = comp ? {16'h0000, lo} : {hi, lo};
        check_equal({32'h0, o_issue.instr}, {32'h0, exp_instr}, "issued instruction");
        check_equal({49'h0, o_issue.pc}, {49'h0, exp_pc}, "issued pc");
        check_equal({63'h0, o_issue.compressed}, {63'h0, comp}, "compressed flag");
        exp_pc = comp ? rv_types_pkg::pc_t'(exp_pc + 1'b1) : rv_types_pkg::pc_t'(exp_pc + 2'd2);
        n_checked++;
    endtask

    always @(negedge i_clk)
    begin
        if (mon_en)
        begin
            if (hold_prev)
            begin
                check_equal({63'h0, o_issue_valid}, {63'h0, valid_prev}, "held o_issue_valid");
                check_equal({16'h0, o_issue}, {16'h0, issue_prev}, "held o_issue");
            end
            if (o_issue_valid && !i_stall)
                check_issue();      // core takes the instruction this cycle
            if (i_flush)
                exp_pc = i_flush_pc;
            hold_prev  = i_stall && !i_flush;
            valid_prev = o_issue_valid;
            issue_prev = o_issue;
        end
    end

    task automatic step();
        @(posedge i_clk);
        #1;
        i_stall = stall_en && ($urandom % 3 == 0);
    endtask

    task automatic do_reset(input rv_types_pkg::pc_t boot);
        mon_en    = 1'b0;
        i_boot_pc = boot;
        i_flush   = 1'b0;
        i_reset_n = 1'b0;
        repeat (3) step();
        check_equal({63'h0, o_mem_req}, 64'h0, "o_mem_req in reset");
        check_equal({63'h0, o_issue_valid}, 64'h0, "o_issue_valid in reset");
        i_reset_n = 1'b1;
        exp_pc    = boot;
        hold_prev = 1'b0;
        n_checked = 0;
        mon_en    = 1'b1;
    endtask

    task automatic wait_for_count(input int target);
        while (n_checked < target)
            step();
    endtask

    task automatic flush_to(input rv_types_pkg::pc_t pc);
        i_flush    = 1'b1;
        i_flush_pc = pc;
        step();
        i_flush    = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_mark);
        $display("%-26s %0d instructions, %0d errors", name, n_checked, n_errors - err_mark);
        n_total += n_checked;
    endtask

    initial
    begin
        rv_types_pkg::pc_t boot;
        int                lat;
        int                err_mark;
        void'($urandom(71366));
        i_reset_n  = 1'b0;
        i_boot_pc  = '0;
        i_flush    = 1'b0;
        i_flush_pc = '0;
        i_stall    = 1'b0;
        stall_en   = 1'b0;
        mon_en     = 1'b0;
        hold_prev  = 1'b0;
        n_errors   = 0;
        n_total    = 0;
        n_checked  = 0;
        for (int i = 0; i < 16384; i++)
            mem[i] = rv_types_pkg::half_t'($urandom);  // low bits pick the length

        err_mark = n_errors;
        boot     = rv_types_pkg::pc_t'($urandom);
        boot[1]  = 1'b0;
        do_reset(boot);
        #2;
        check_equal({63'h0, o_mem_req}, 64'h1, "o_mem_req after reset");
        check_equal({50'h0, o_mem_addr}, {50'h0, boot[15:2]}, "o_mem_addr after reset");
        check_equal({63'h0, o_issue_valid}, 64'h0, "o_issue_valid after reset");
        lat = 0;
        while (!o_issue_valid && lat < 10)
        begin
            step();
            lat++;
        end
        check_equal(64'(lat), 64'(3), "cycles to first issue");
        check_equal({49'h0, o_issue.pc}, {49'h0, boot}, "first issued pc");
        wait_for_count(N_FIRST);
        report_test("test 1 reset, first issue", err_mark);

        err_mark = n_errors;
        boot     = rv_types_pkg::pc_t'($urandom);
        boot[1]  = 1'b0;
        do_reset(boot);
        wait_for_count(N_STREAM);
        report_test("test 2 even stream", err_mark);

        // odd start where the first parcel is the upper half of the word
        err_mark = n_errors;
        boot     = rv_types_pkg::pc_t'($urandom);
        boot[1]  = 1'b1;
        do_reset(boot);
        while (!o_issue_valid)
            step();
        check_equal({49'h0, o_issue.pc}, {49'h0, boot}, "first pc after odd boot");
        wait_for_count(N_ODD + 1);
        report_test("test 3 odd boot", err_mark);

        err_mark = n_errors;
        stall_en = 1'b1;
        do_reset(rv_types_pkg::pc_t'($urandom));
        wait_for_count(N_STALL);
        report_test("test 4 random stalls", err_mark);

        err_mark = n_errors;
        do_reset(rv_types_pkg::pc_t'($urandom));
        for (int f = 0; f < N_FLUSHES; f++)
        begin
            wait_for_count(n_checked + 4 + ($urandom % 12));
            repeat ($urandom % 4) step();
            flush_to(rv_types_pkg::pc_t'($urandom));
        end
        wait_for_count(n_checked + N_TAIL);
        stall_en = 1'b0;
        report_test("test 5 flushes", err_mark);

        $display("tests 5, instructions checked %0d, errors %0d", n_total, n_errors);
        if (n_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: tb.f
source/rv_types_pkg.sv
source/rv_fetch_pkg.sv
source/rv_fetch_ctrl.sv
source/rv_fetch_buf.sv
source/rv_instr_issue.sv
source/rv_fetch_top.sv
tests/tb_rv_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the fetch front end testbench with Verilator, runs it and
# decides the result from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=sim_tb_rv_fetch_top
LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f tb.f \
    --top-module tb_rv_fetch_top \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the pass line only when every check held
if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "simulation passed, log in $LOG"
    exit 0
else
    echo "simulation failed, log in $LOG"
    exit 1
fi
